// ==== Makefile ====
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only -Wall
SIM_FLAGS  ?= --binary --timing
TOP        := csr_unit_tb
FILELIST   := list.f
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TB PASSED" $(LOG) || (echo "No pass message in log"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== design/csr_exec.sv ====
//************************************************************
// CSR executor
// Read-modify-write on CSR storage, old value to rd
//************************************************************
`timescale 1ns/1ps
`default_nettype none

module csr_exec import rv_isa_pkg::*, csr_pipe_pkg::*; (
	input  wire logic          CLK,
	input  wire logic          arst_n,
	input  wire logic          csr_exeparam_valid,
	input  wire csr_exeparam_t csr_exeparam,
	output csr_addr_t          csr_rd_addr,
	input  wire xlen_t         csr_rd_data,
	output logic               csr_we,
	output csr_addr_t          csr_wr_addr,
	output xlen_t              csr_wr_data,
	output logic               csr_wb_valid,
	output phy_idx_t           csr_wb_idx,
	output xlen_t              csr_wb_data
);

	logic op_rw, op_rs, op_rc;
	phy_idx_t rd;
	xlen_t operand;
	csr_addr_t addr;
	csr_op_e op;
	exec_state_e state;

	assign {op_rw, op_rs, op_rc, rd, operand, addr} = csr_exeparam;

	// One-hot flags to operation
	always_comb begin
		case (1'b1)
			op_rw: op = CSR_OP_RW;
			op_rs: op = CSR_OP_RS;
			op_rc: op = CSR_OP_RC;
			default: op = CSR_OP_RW;      // No flag set
		endcase
	end

	assign csr_rd_addr = addr;
	assign csr_wr_addr = addr;
	assign csr_we = csr_exeparam_valid;   // Written at this edge

	always_comb begin
		case (op)
			CSR_OP_RW: csr_wr_data = operand;
			CSR_OP_RS: csr_wr_data = csr_rd_data | operand;
			default: csr_wr_data = csr_rd_data & ~operand;
		endcase
	end

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) state <= IDLE;
		else state <= csr_exeparam_valid ? WRITE : IDLE;
	end

	always_ff @(posedge CLK) begin
		if (csr_exeparam_valid) begin
			csr_wb_idx <= rd;
			csr_wb_data <= csr_rd_data;   // Old value goes to rd
		end
	end

	assign csr_wb_valid = (state == WRITE);

endmodule

`default_nettype wire

// ==== design/csr_file.sv ====
//************************************************************
// Machine CSR storage
// mscratch, mtvec and mepc; other addresses read zero
//************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "csr_settings.svh"

module csr_file import rv_isa_pkg::*; (
	input  wire logic      CLK,
	input  wire logic      arst_n,
	input  wire csr_addr_t rd_addr,
	output xlen_t          rd_data,
	input  wire logic      we,
	input  wire csr_addr_t wr_addr,
	input  wire xlen_t     wr_data
);

	xlen_t mscratch;
	xlen_t mtvec;
	xlen_t mepc;

	always_comb begin
		case (rd_addr)
			`CSR_ADDR_MSCRATCH: rd_data = mscratch;
			`CSR_ADDR_MTVEC: rd_data = mtvec;
			`CSR_ADDR_MEPC: rd_data = mepc;
			default: rd_data = '0;          // Not implemented
		endcase
	end

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			mscratch <= '0;
			mtvec <= '0;
			mepc <= '0;
		end else if (we) begin
			case (wr_addr)
				`CSR_ADDR_MSCRATCH: mscratch <= wr_data;
				`CSR_ADDR_MTVEC: mtvec <= wr_data;
				`CSR_ADDR_MEPC: mepc <= wr_data & ~xlen_t'(3);  // IALIGN
				default: ;                      // Write ignored
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== design/csr_issue.sv ====
//************************************************************
// CSR issue stage
// Waits for rs1 and commit order, then registers the
// execution packet for the executor
//************************************************************
`timescale 1ns/1ps
`default_nettype none

module csr_issue import rv_isa_pkg::*, csr_pipe_pkg::*; (
	input  wire logic            CLK,
	input  wire logic            arst_n,
	output logic                 csr_fifo_pop,
	input  wire logic            csr_fifo_empty,
	input  wire csr_issue_info_t csr_issue_info,
	output phy_idx_t             regfile_read_idx,
	input  wire xlen_t           regfile_read_data,
	input  wire phy_log_t        wb_log,
	input  wire logic            csr_ilp_ready,
	output logic                 csr_exeparam_valid,
	output csr_exeparam_t        csr_exeparam
);

	logic op_rw, op_rs, op_rc;
	logic op_rwi, op_rsi, op_rci;
	csr_addr_t addr;
	phy_idx_t rd;
	phy_idx_t rs1;

	logic use_reg, use_imm;
	logic csr_rw, csr_rs, csr_rc;
	logic rs1_ready;
	xlen_t operand;
	csr_exeparam_t exeparam_next;

	assign {op_rw, op_rs, op_rc, op_rwi, op_rsi, op_rci, addr, rd, rs1} = csr_issue_info;

	assign use_reg = op_rw | op_rs | op_rc;
	assign use_imm = op_rwi | op_rsi | op_rci;

	// Immediate and register forms share one operation
	assign csr_rw = op_rw | op_rwi;
	assign csr_rs = op_rs | op_rsi;
	assign csr_rc = op_rc | op_rci;

	assign regfile_read_idx = rs1;

	// x0 never waits on a producer
	assign rs1_ready = wb_log[rs1] | (rs1[$bits(phy_idx_t)-1 -: 5] == 5'd0);

	assign operand = ({$bits(xlen_t){use_reg}} & regfile_read_data)
		| ({$bits(xlen_t){use_imm}} & xlen_t'(rs1));

	assign exeparam_next = {csr_rw, csr_rs, csr_rc, rd, operand, addr};

	// Older instructions retired and source available
	assign csr_fifo_pop = ~csr_fifo_empty
		& ((use_reg & rs1_ready) | use_imm)
		& csr_ilp_ready;

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			csr_exeparam_valid <= 1'b0;
		end else begin
			csr_exeparam_valid <= csr_fifo_pop;
		end
	end

	always_ff @(posedge CLK) begin
		if (csr_fifo_pop) csr_exeparam <= exeparam_next;
	end

endmodule

`default_nettype wire

// ==== design/csr_issue_fifo.sv ====
//************************************************************
// CSR issue queue
// In-order buffer of decoded CSR instructions
//************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "csr_settings.svh"

module csr_issue_fifo import csr_pipe_pkg::*; (
	input  wire logic            CLK,
	input  wire logic            arst_n,
	input  wire logic            disp_valid,
	input  wire csr_issue_info_t disp_info,
	output logic                 disp_ready,
	input  wire logic            csr_fifo_pop,
	output logic                 csr_fifo_empty,
	output csr_issue_info_t      csr_issue_info
);

	localparam int unsigned DEPTH = `CSR_FIFO_DEPTH;
	localparam int unsigned AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	csr_issue_info_t mem [DEPTH];
	logic [AW-1:0] rd_ptr, wr_ptr;
	logic [AW:0] count;
	logic push;

	function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] p);
		return (p == AW'(DEPTH-1)) ? '0 : p + 1'b1;
	endfunction

	assign push = disp_valid & disp_ready;
	assign disp_ready = (count != (AW+1)'(DEPTH));  // Not full
	assign csr_fifo_empty = (count == '0);
	assign csr_issue_info = mem[rd_ptr];            // Head, no pop needed

	always_ff @(posedge CLK) begin
		if (push) mem[wr_ptr] <= disp_info;
	end

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (push) wr_ptr <= next_ptr(wr_ptr);
			if (csr_fifo_pop) rd_ptr <= next_ptr(rd_ptr);
			case ({push, csr_fifo_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;        // Both or neither
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== design/csr_pipe_pkg.sv ====
//************************************************************
// CSR pipeline types
// Issue info, execution packet and executor state
//************************************************************
`default_nettype none

package csr_pipe_pkg;

	import rv_isa_pkg::*;

	// {rw, rs, rc, rwi, rsi, rci, addr, rd, rs1}
	// rs1 holds the zero-extended immediate for the i-forms
	typedef logic [6+$bits(csr_addr_t)+2*$bits(phy_idx_t)-1:0] csr_issue_info_t;

	// {rw, rs, rc, rd, operand, addr}
	typedef logic [3+$bits(phy_idx_t)+$bits(xlen_t)+$bits(csr_addr_t)-1:0]
		csr_exeparam_t;

	typedef enum logic {
		IDLE,   // Nothing to write back
		WRITE   // Old CSR value on the write-back port
	} exec_state_e;

endpackage

`default_nettype wire

// ==== design/csr_settings.svh ====
//************************************************************
// CSR unit settings
// Data width, rename bits, queue depth and CSR address map
//************************************************************
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

`define XLEN 64                   // Data word width
`define RB 2                      // Rename bits per arch register
`define CSR_FIFO_DEPTH 4          // Dispatch queue entries

// Implemented machine CSRs
`define CSR_ADDR_MSCRATCH 12'h340
`define CSR_ADDR_MTVEC 12'h305
`define CSR_ADDR_MEPC 12'h341

`endif

// ==== design/csr_unit_top.sv ====
//************************************************************
// CSR unit top
// Queue, issue, register file, executor and CSR storage
//************************************************************
`timescale 1ns/1ps
`default_nettype none

module csr_unit_top import rv_isa_pkg::*, csr_pipe_pkg::*; (
	input  wire logic            CLK,
	input  wire logic            arst_n,
	input  wire logic            disp_valid,
	input  wire csr_issue_info_t disp_info,
	output logic                 disp_ready,
	input  wire logic            wb_valid,
	input  wire phy_idx_t        wb_idx,
	input  wire xlen_t           wb_data,
	input  wire logic            csr_ilp_ready,
	output logic                 csr_wb_valid,
	output phy_idx_t             csr_wb_idx,
	output xlen_t                csr_wb_data
);

	logic csr_fifo_pop, csr_fifo_empty;
	csr_issue_info_t csr_issue_info;
	phy_idx_t regfile_read_idx;
	xlen_t regfile_read_data;
	phy_log_t wb_log;
	logic csr_exeparam_valid;
	csr_exeparam_t csr_exeparam;
	csr_addr_t csr_rd_addr, csr_wr_addr;
	xlen_t csr_rd_data, csr_wr_data;
	logic csr_we;
	logic alloc_valid;
	phy_idx_t alloc_idx;

	// rd sits just above rs1 in the issue info
	assign alloc_valid = disp_valid & disp_ready;
	assign alloc_idx = disp_info[$bits(phy_idx_t) +: $bits(phy_idx_t)];

	csr_issue_fifo u_fifo (.CLK, .arst_n, .disp_valid, .disp_info, .disp_ready,
		.csr_fifo_pop, .csr_fifo_empty, .csr_issue_info);

	csr_issue u_issue (.CLK, .arst_n, .csr_fifo_pop, .csr_fifo_empty, .csr_issue_info,
		.regfile_read_idx, .regfile_read_data, .wb_log, .csr_ilp_ready,
		.csr_exeparam_valid, .csr_exeparam);

	phy_regfile u_regfile (.CLK, .arst_n, .read_idx(regfile_read_idx),
		.read_data(regfile_read_data), .wb_log, .alloc_valid, .alloc_idx,
		.wb_valid, .wb_idx, .wb_data, .csr_wb_valid, .csr_wb_idx, .csr_wb_data);

	csr_exec u_exec (.CLK, .arst_n, .csr_exeparam_valid, .csr_exeparam, .csr_rd_addr,
		.csr_rd_data, .csr_we, .csr_wr_addr, .csr_wr_data, .csr_wb_valid,
		.csr_wb_idx, .csr_wb_data);

	csr_file u_csr_file (.CLK, .arst_n, .rd_addr(csr_rd_addr), .rd_data(csr_rd_data),
		.we(csr_we), .wr_addr(csr_wr_addr), .wr_data(csr_wr_data));

endmodule

`default_nettype wire

// ==== design/phy_regfile.sv ====
//************************************************************
// Physical integer register file
// Two write ports and a write-back log bit per register
//************************************************************
`timescale 1ns/1ps
`default_nettype none

module phy_regfile import rv_isa_pkg::*; (
	input  wire logic     CLK,
	input  wire logic     arst_n,
	input  wire phy_idx_t read_idx,
	output xlen_t         read_data,
	output phy_log_t      wb_log,
	input  wire logic     alloc_valid,
	input  wire phy_idx_t alloc_idx,
	input  wire logic     wb_valid,
	input  wire phy_idx_t wb_idx,
	input  wire xlen_t    wb_data,
	input  wire logic     csr_wb_valid,
	input  wire phy_idx_t csr_wb_idx,
	input  wire xlen_t    csr_wb_data
);

	localparam int unsigned PHY_NUM = 2**$bits(phy_idx_t);

	xlen_t regs [PHY_NUM];

	function automatic logic is_x0(input phy_idx_t idx);
		return idx[$bits(phy_idx_t)-1 -: 5] == 5'd0;
	endfunction

	assign read_data = regs[read_idx];

	//************************************************************
	// Register and log update
	//************************************************************
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < PHY_NUM; i++) begin
				regs[i] <= '0;
			end
			wb_log <= '1;                       // All values valid
		end else begin
			if (wb_valid && !is_x0(wb_idx)) begin
				regs[wb_idx] <= wb_data;
				wb_log[wb_idx] <= 1'b1;
			end
			if (csr_wb_valid && !is_x0(csr_wb_idx)) begin
				regs[csr_wb_idx] <= csr_wb_data;
				wb_log[csr_wb_idx] <= 1'b1;
			end
			// New producer wins over a write in the same cycle
			if (alloc_valid && !is_x0(alloc_idx)) begin
				wb_log[alloc_idx] <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/rv_isa_pkg.sv ====
//************************************************************
// RISC-V architectural types
// Data word, register indices, CSR address, CSR operation
//************************************************************
`default_nettype none

`include "csr_settings.svh"

package rv_isa_pkg;

	typedef logic [`XLEN-1:0] xlen_t;           // One data word
	typedef logic [(5+`RB)-1:0] phy_idx_t;      // Arch number in upper 5 bits
	typedef logic [2**(5+`RB)-1:0] phy_log_t;   // One log bit per physical reg
	typedef logic [11:0] csr_addr_t;

	// Read-modify-write kind, immediate forms folded in
	typedef enum logic [1:0] {
		CSR_OP_RW,
		CSR_OP_RS,
		CSR_OP_RC
	} csr_op_e;

endpackage

`default_nettype wire

// ==== list.f ====
+incdir+design
design/rv_isa_pkg.sv
design/csr_pipe_pkg.sv
design/csr_issue_fifo.sv
design/csr_issue.sv
design/phy_regfile.sv
design/csr_exec.sv
design/csr_file.sv
design/csr_unit_top.sv
verification/tb_clock_gen.sv
verification/csr_unit_tb.sv

// ==== verification/csr_unit_tb.sv ====
//************************************************************
// CSR unit testbench
// Directed and LCG-driven tests against a model of the
// CSRs and the physical registers
//************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "csr_settings.svh"

module csr_unit_tb import rv_isa_pkg::*, csr_pipe_pkg::*; ();

	localparam int WAIT_LIMIT = 200;       // Cycles per wait loop
	localparam logic [31:0] SEED = 32'd76542;
	localparam int K_RW = 0;
	localparam int K_RS = 1;
	localparam int K_RWI = 3;
	localparam int K_RSI = 4;
	localparam int K_RCI = 5;
	localparam csr_addr_t ADDR_UNIMP = 12'h7c0;

	logic CLK;
	logic arst_n;
	logic disp_valid;
	csr_issue_info_t disp_info;
	logic disp_ready;
	logic wb_valid;
	phy_idx_t wb_idx;
	xlen_t wb_data;
	logic csr_ilp_ready;
	logic csr_wb_valid;
	phy_idx_t csr_wb_idx;
	xlen_t csr_wb_data;

	xlen_t csr_model [csr_addr_t];             // Implemented CSRs only
	xlen_t reg_model [2**$bits(phy_idx_t)];
	phy_idx_t exp_idx_q [$];
	xlen_t exp_data_q [$];
	logic [31:0] lcg_state;
	csr_addr_t addr_tab [4] = '{`CSR_ADDR_MSCRATCH, `CSR_ADDR_MTVEC, `CSR_ADDR_MEPC,
		ADDR_UNIMP};

	tb_clock_gen u_clk (.CLK, .arst_n);

	csr_unit_top dut (.CLK, .arst_n, .disp_valid, .disp_info, .disp_ready, .wb_valid,
		.wb_idx, .wb_data, .csr_ilp_ready, .csr_wb_valid, .csr_wb_idx, .csr_wb_data);

	//************************************************************
	// Helpers
	//************************************************************
	task automatic abort_run();
		$display("TB FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		assert (got === exp) else begin
			$display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic int unsigned rand_below(input int unsigned n);
		return (lcg_next() >> 16) % n;           // Upper bits have the longer period
	endfunction

	function automatic phy_idx_t phys(input logic [4:0] arch, input logic [`RB-1:0] ren);
		return {arch, ren};
	endfunction

	function automatic logic [4:0] arch_of(input phy_idx_t idx);
		return idx[$bits(phy_idx_t)-1 -: 5];
	endfunction

	task automatic wait_reset();
		int cycles;
		cycles = 0;
		@(negedge CLK);
		while (!arst_n && cycles < WAIT_LIMIT) begin
			@(negedge CLK);
			cycles++;
		end
		assert (arst_n) else begin
			$display("reset was never released");
			abort_run();
		end
	endtask

	task automatic dispatch(input csr_issue_info_t info);
		int cycles;
		cycles = 0;
		while (!disp_ready && cycles < WAIT_LIMIT) begin
			@(negedge CLK);
			cycles++;
		end
		assert (disp_ready) else begin
			$display("disp_ready stayed low for %0d cycles", WAIT_LIMIT);
			abort_run();
		end
		disp_valid = 1'b1;
		disp_info = info;
		@(negedge CLK);
		disp_valid = 1'b0;
	endtask

	task automatic load_reg(input phy_idx_t idx, input xlen_t data);
		wb_valid = 1'b1;
		wb_idx = idx;
		wb_data = data;
		@(negedge CLK);
		wb_valid = 1'b0;
		if (arch_of(idx) != 5'd0) reg_model[idx] = data;   // x0 stays zero
	endtask

	// Applies the op to the model in program order, then pushes it
	task automatic issue_op(input int kind, input csr_addr_t addr, input phy_idx_t rd,
		input phy_idx_t src);
		xlen_t operand;
		xlen_t old_val;
		xlen_t new_val;
		csr_issue_info_t info;
		operand = (kind >= K_RWI) ? xlen_t'(src) : reg_model[src];
		old_val = csr_model.exists(addr) ? csr_model[addr] : '0;
		case (kind % 3)
			0: new_val = operand;
			1: new_val = old_val | operand;
			default: new_val = old_val & ~operand;
		endcase
		if (addr == `CSR_ADDR_MEPC) new_val[1:0] = 2'b00;   // mepc is 4-byte aligned
		if (csr_model.exists(addr)) csr_model[addr] = new_val;
		if (arch_of(rd) != 5'd0) reg_model[rd] = old_val;
		exp_idx_q.push_back(rd);
		exp_data_q.push_back(old_val);
		info = {6'b100000 >> kind, addr, rd, src};
		dispatch(info);
	endtask

	task automatic expect_wb();
		int cycles;
		cycles = 0;
		do begin
			@(negedge CLK);
			cycles++;
		end while (!csr_wb_valid && cycles < WAIT_LIMIT);
		assert (csr_wb_valid) else begin
			$display("csr_wb_valid did not rise within %0d cycles", WAIT_LIMIT);
			abort_run();
		end
		assert (exp_idx_q.size() > 0) else begin
			$display("write-back arrived with no instruction outstanding");
			abort_run();
		end
		check_value("csr_wb_idx", csr_wb_idx, exp_idx_q.pop_front());
		check_value("csr_wb_data", csr_wb_data, exp_data_q.pop_front());
	endtask

	task automatic expect_no_wb(input int cycles);
		repeat (cycles) begin
			@(negedge CLK);
			check_value("csr_wb_valid", csr_wb_valid, 0);
		end
	endtask

	//************************************************************
	// Tests
	//************************************************************
	task automatic test_reset();
		check_value("csr_wb_valid", csr_wb_valid, 0);
		check_value("disp_ready", disp_ready, 1);
		expect_no_wb(10);
	endtask

	task automatic test_rw_with_source();
		load_reg(phys(5'd5, 2'd1), 64'hdead_beef_0123_4567);
		issue_op(K_RW, `CSR_ADDR_MSCRATCH, phys(5'd6, 2'd0), phys(5'd5, 2'd1));
		expect_wb();
		load_reg(phys(5'd9, 2'd3), 64'h0f0f_0000_a5a5_1111);
		issue_op(K_RW, `CSR_ADDR_MSCRATCH, phys(5'd7, 2'd2), phys(5'd9, 2'd3));
		expect_wb();                              // Old mscratch from the first write
		issue_op(K_RS, `CSR_ADDR_MSCRATCH, phys(5'd8, 2'd0), phys(5'd0, 2'd0));
		expect_wb();
	endtask

	task automatic test_imm_ops();
		issue_op(K_RWI, `CSR_ADDR_MTVEC, phys(5'd10, 2'd0), phy_idx_t'(29));
		expect_wb();
		issue_op(K_RSI, `CSR_ADDR_MTVEC, phys(5'd10, 2'd1), phy_idx_t'(2));
		expect_wb();
		issue_op(K_RCI, `CSR_ADDR_MTVEC, phys(5'd10, 2'd2), phy_idx_t'(8));
		expect_wb();
		issue_op(K_RSI, `CSR_ADDR_MTVEC, phys(5'd10, 2'd3), phy_idx_t'(0));
		expect_wb();
		load_reg(phys(5'd12, 2'd0), 64'h8000_0000_0000_1237);
		issue_op(K_RW, `CSR_ADDR_MEPC, phys(5'd13, 2'd0), phys(5'd12, 2'd0));
		expect_wb();
		issue_op(K_RS, `CSR_ADDR_MEPC, phys(5'd13, 2'd1), phys(5'd0, 2'd0));
		expect_wb();
		check_value("csr_wb_data[1:0]", csr_wb_data[1:0], 0);
		issue_op(K_RWI, ADDR_UNIMP, phys(5'd14, 2'd0), phy_idx_t'(31));
		expect_wb();
		issue_op(K_RS, ADDR_UNIMP, phys(5'd14, 2'd1), phys(5'd0, 2'd0));
		expect_wb();
		check_value("csr_wb_data", csr_wb_data, 0);
	endtask

	// Second op reads the register that the first op produces
	task automatic test_raw_stall();
		csr_ilp_ready = 1'b0;
		issue_op(K_RS, `CSR_ADDR_MSCRATCH, phys(5'd20, 2'd2), phys(5'd0, 2'd0));
		issue_op(K_RW, `CSR_ADDR_MEPC, phys(5'd21, 2'd0), phys(5'd20, 2'd2));
		expect_no_wb(8);
		csr_ilp_ready = 1'b1;
		expect_wb();
		expect_wb();
		issue_op(K_RS, `CSR_ADDR_MEPC, phys(5'd22, 2'd0), phys(5'd0, 2'd0));
		expect_wb();                              // mepc holds the produced value
	endtask

	task automatic test_commit_backpressure();
		csr_ilp_ready = 1'b0;
		for (int i = 0; i < `CSR_FIFO_DEPTH; i++) begin
			issue_op(K_RSI, `CSR_ADDR_MSCRATCH, phys(5'(16 + i), 2'd1), phy_idx_t'(i + 1));
		end
		check_value("disp_ready", disp_ready, 0);
		expect_no_wb(6);
		csr_ilp_ready = 1'b1;
		repeat (`CSR_FIFO_DEPTH) expect_wb();
	endtask

	task automatic test_random();
		int kind;
		csr_addr_t addr;
		phy_idx_t rd;
		phy_idx_t src;
		for (int n = 0; n < 40; n++) begin
			kind = int'(rand_below(6));
			addr = addr_tab[rand_below(4)];
			rd = phys(5'(rand_below(32)), `RB'(rand_below(4)));
			if (kind >= K_RWI) begin
				src = phy_idx_t'(rand_below(32));  // 5-bit immediate
			end else begin
				src = phys(5'(rand_below(32)), `RB'(rand_below(4)));
				if (rd == src) rd = rd ^ phy_idx_t'(4);  // Would wait on itself
				if (arch_of(src) != 5'd0) load_reg(src, {lcg_next(), lcg_next()});
			end
			issue_op(kind, addr, rd, src);
			expect_wb();
		end
	endtask

	initial begin
		disp_valid = 1'b0;
		disp_info = '0;
		wb_valid = 1'b0;
		wb_idx = '0;
		wb_data = '0;
		csr_ilp_ready = 1'b1;
		lcg_state = SEED;
		foreach (reg_model[i]) reg_model[i] = '0;
		csr_model[`CSR_ADDR_MSCRATCH] = '0;
		csr_model[`CSR_ADDR_MTVEC] = '0;
		csr_model[`CSR_ADDR_MEPC] = '0;
		wait_reset();
		test_reset();
		test_rw_with_source();
		test_imm_ops();
		test_raw_stall();
		test_commit_backpressure();
		test_random();
		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
//************************************************************
// Testbench clock and reset
// 40 ns clock, reset held low for 5 cycles
//************************************************************
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic CLK,
	output logic arst_n
);

	localparam int HALF_PERIOD = 20;       // 40 ns period
	localparam int RESET_CYCLES = 5;

	initial CLK = 1'b0;
	always #HALF_PERIOD CLK = ~CLK;

	initial begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		@(negedge CLK);                    // Release away from the active edge
		arst_n = 1'b1;
	end

endmodule

`default_nettype wire
